//--- verilog/csr_defs_pkg.sv
package csr_defs_pkg;

  localparam int xlen_w = 32;

  // CSR access kinds, the immediate forms share the same codes
  typedef enum logic [1:0] {
    csr_op_none = 2'd0,
    csr_op_rw   = 2'd1,
    csr_op_rs   = 2'd2,
    csr_op_rc   = 2'd3
  } csr_op_t;

  typedef enum logic [1:0] {
    prv_u = 2'd0,
    prv_s = 2'd1,
    prv_m = 2'd3
  } priv_t;

  // --------------------
  // Implemented CSRs
  // --------------------
  localparam logic [11:0] csr_mstatus  = 12'h300;
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;
  localparam logic [11:0] csr_mcause   = 12'h342;
  localparam logic [11:0] csr_minstret = 12'hb02;

  // xIE, xPIE, SPP and MPP
  localparam logic [xlen_w-1:0] mstatus_wmask = 32'h0000_19bb;

endpackage

//--- verilog/csu_types_pkg.sv
package csu_types_pkg;

  localparam int rnid_w = 6;

  // One instruction as it leaves the scheduler
  typedef struct packed {
    logic              valid;
    logic [31:0]       inst;
    logic              rs1_valid;
    logic [rnid_w-1:0] rs1_rnid;
    logic              rd_valid;
    logic [rnid_w-1:0] rd_rnid;
  } issue_t;

  // Write-back and forwarding bus entry
  typedef struct packed {
    logic                             valid;
    logic [rnid_w-1:0]                rnid;
    logic [csr_defs_pkg::xlen_w-1:0]  data;
  } phy_wr_t;

  // --------------------
  // Completion causes
  // --------------------
  typedef enum logic [2:0] {
    mret         = 3'd0,
    sret         = 3'd1,
    uret         = 3'd2,
    ecall_u      = 3'd3,
    ecall_s      = 3'd4,
    ecall_m      = 3'd5,
    illegal_inst = 3'd6,
    silent_flush = 3'd7  // Refetch after a CSR side effect
  } except_t;

endpackage

//--- verilog/csu_ifs.sv
// CSR read port, answered in the same cycle
interface csr_rd_if
  import csr_defs_pkg::*;
();

  logic              valid;
  logic [11:0]       addr;
  logic [xlen_w-1:0] data;
  logic              resp_error;

  modport master (
    output valid,
    output addr,
    input  data,
    input  resp_error
  );

  modport slave (
    input  valid,
    input  addr,
    output data,
    output resp_error
  );

endinterface

// CSR write port, committed on the next edge
interface csr_wr_if
  import csr_defs_pkg::*;
();

  logic              valid;
  logic [11:0]       addr;
  logic [xlen_w-1:0] data;
  logic              resp_error;

  modport master (output valid, output addr, output data, input resp_error);

  modport slave (input valid, input addr, input data, output resp_error);

endinterface

//--- verilog/csu_decoder.sv
module csu_decoder
  import csr_defs_pkg::*;
(
  input  logic [31:0] i_inst,
  output csr_op_t     o_op,
  output logic        o_is_mret,
  output logic        o_is_sret,
  output logic        o_is_uret,
  output logic        o_is_ecall,
  output logic        o_is_ebreak,
  output logic        o_is_fence_i,
  output logic        o_is_sfence_vma,
  output logic        o_csr_update
);

  typedef enum logic [6:0] {
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_t;

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        regs_zero;

  assign opcode    = opcode_t'(i_inst[6:0]);
  assign funct3    = i_inst[14:12];
  assign funct12   = i_inst[31:20];
  assign regs_zero = (i_inst[19:15] == 5'd0) && (i_inst[11:7] == 5'd0);

  always_comb begin
    o_op            = csr_op_none;
    o_is_mret       = 1'b0;
    o_is_sret       = 1'b0;
    o_is_uret       = 1'b0;
    o_is_ecall      = 1'b0;
    o_is_ebreak     = 1'b0;
    o_is_fence_i    = 1'b0;
    o_is_sfence_vma = 1'b0;
    if (opcode == opc_system) begin
      case (funct3)
        3'b001, 3'b101: o_op = csr_op_rw;  // Register and immediate forms
        3'b010, 3'b110: o_op = csr_op_rs;
        3'b011, 3'b111: o_op = csr_op_rc;
        3'b000: begin
          o_is_ecall  = regs_zero && (funct12 == 12'h000);
          o_is_ebreak = regs_zero && (funct12 == 12'h001);
          o_is_uret   = regs_zero && (funct12 == 12'h002);
          o_is_sret   = regs_zero && (funct12 == 12'h102);
          o_is_mret   = regs_zero && (funct12 == 12'h302);
          o_is_sfence_vma = (i_inst[31:25] == 7'b0001001) && (i_inst[11:7] == 5'd0);
        end
        default: ;
      endcase
    end else if (opcode == opc_misc_mem) begin
      o_is_fence_i = (funct3 == 3'b001);
    end
  end

  assign o_csr_update = (o_op != csr_op_none);

endmodule

//--- verilog/csu_pipe.sv
module csu_pipe
  import csr_defs_pkg::*;
  import csu_types_pkg::*;
#(
  parameter int num_tgt = 2,
  parameter int index_w = 8
)(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  issue_t              i_issue,
  input  logic [index_w-1:0]  i_index,

  output logic                o_rs1_rd_valid,
  output logic [rnid_w-1:0]   o_rs1_rnid,
  input  logic [xlen_w-1:0]   i_rs1_data,

  input  phy_wr_t             i_tgt [num_tgt],
  input  priv_t               i_priv,

  output logic                o_early_valid,
  output logic [rnid_w-1:0]   o_early_rnid,
  output phy_wr_t             o_wr,

  output logic                o_done,
  output logic [index_w-1:0]  o_done_index,
  output logic                o_except_valid,
  output except_t             o_except_type,

  output logic                o_sfence_valid,
  output logic                o_sfence_rs1_x0,
  output logic [xlen_w-1:0]   o_sfence_vaddr,
  output logic                o_fence_i,

  csr_rd_if.master            rd,
  csr_wr_if.master            wr
);

  typedef struct packed {
    csr_op_t op;
    logic    is_mret;
    logic    is_sret;
    logic    is_uret;
    logic    is_ecall;
    logic    is_fence_i;
    logic    is_sfence_vma;
    logic    csr_update;
  } pipe_ctrl_t;

  pipe_ctrl_t          w_ex0_ctrl;

  issue_t              r_ex1_issue;
  pipe_ctrl_t          r_ex1_ctrl;
  logic [index_w-1:0]  r_ex1_index;

  issue_t              r_ex2_issue;
  pipe_ctrl_t          r_ex2_ctrl;
  logic [index_w-1:0]  r_ex2_index;
  logic [num_tgt-1:0]  w_ex2_fwd_hit;
  logic [xlen_w-1:0]   w_ex2_fwd_data;
  logic [xlen_w-1:0]   w_ex2_rs1;
  logic [xlen_w-1:0]   w_ex2_result;

  issue_t              r_ex3_issue;
  pipe_ctrl_t          r_ex3_ctrl;
  logic [index_w-1:0]  r_ex3_index;
  logic [xlen_w-1:0]   r_ex3_result;
  logic [xlen_w-1:0]   r_ex3_csr_data;
  logic                r_ex3_rd_error;
  logic                w_ex3_wr_error;
  logic                w_ex3_rs1_x0;

  csu_decoder u_decoder (
    .i_inst          (i_issue.inst),
    .o_op            (w_ex0_ctrl.op),
    .o_is_mret       (w_ex0_ctrl.is_mret),
    .o_is_sret       (w_ex0_ctrl.is_sret),
    .o_is_uret       (w_ex0_ctrl.is_uret),
    .o_is_ecall      (w_ex0_ctrl.is_ecall),
    .o_is_ebreak     (),
    .o_is_fence_i    (w_ex0_ctrl.is_fence_i),
    .o_is_sfence_vma (w_ex0_ctrl.is_sfence_vma),
    .o_csr_update    (w_ex0_ctrl.csr_update)
  );

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
      r_ex3_issue <= '0;
      r_ex3_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
      r_ex3_issue <= r_ex2_issue;
      r_ex3_ctrl  <= r_ex2_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_index    <= i_index;
    r_ex2_index    <= r_ex1_index;
    r_ex3_index    <= r_ex2_index;
    r_ex3_result   <= w_ex2_result;
    r_ex3_csr_data <= rd.data;
    r_ex3_rd_error <= rd.valid & rd.resp_error;
  end

  // --------------------
  // ex1
  // --------------------
  assign o_rs1_rd_valid = r_ex1_issue.valid & r_ex1_issue.rs1_valid;
  assign o_rs1_rnid     = r_ex1_issue.rs1_rnid;
  assign o_early_valid  = r_ex1_issue.valid & r_ex1_issue.rd_valid;
  assign o_early_rnid   = r_ex1_issue.rd_rnid;

  // --------------------
  // ex2
  // --------------------
  for (genvar g = 0; g < num_tgt; g++) begin : g_fwd
    assign w_ex2_fwd_hit[g] = r_ex2_issue.rs1_valid & i_tgt[g].valid &
                              (i_tgt[g].rnid == r_ex2_issue.rs1_rnid) &
                              (i_tgt[g].rnid != '0);  // x0 never forwards
  end

  always_comb begin
    w_ex2_fwd_data = '0;
    for (int i = 0; i < num_tgt; i++) begin
      if (w_ex2_fwd_hit[i]) w_ex2_fwd_data = w_ex2_fwd_data | i_tgt[i].data;
    end
  end

  assign w_ex2_rs1 = !r_ex2_issue.rs1_valid ? {{(xlen_w-5){1'b0}}, r_ex2_issue.inst[19:15]} :
                     |w_ex2_fwd_hit         ? w_ex2_fwd_data :
                                              i_rs1_data;

  assign rd.valid = r_ex2_issue.valid & r_ex2_ctrl.csr_update;
  assign rd.addr  = r_ex2_issue.inst[31:20];

  always_comb begin
    case (r_ex2_ctrl.op)
      csr_op_rs: w_ex2_result = rd.data | w_ex2_rs1;
      csr_op_rc: w_ex2_result = rd.data & ~w_ex2_rs1;
      default:   w_ex2_result = w_ex2_rs1;  // rw, and the sfence address
    endcase
  end

  // --------------------
  // ex3
  // --------------------
  assign w_ex3_rs1_x0 = (r_ex3_issue.inst[19:15] == 5'd0);

  assign wr.valid = r_ex3_issue.valid & r_ex3_ctrl.csr_update &
                    !(((r_ex3_ctrl.op == csr_op_rs) || (r_ex3_ctrl.op == csr_op_rc)) &
                      w_ex3_rs1_x0);
  assign wr.addr  = r_ex3_issue.inst[31:20];
  assign wr.data  = r_ex3_result;
  assign w_ex3_wr_error = wr.valid & wr.resp_error;

  assign o_wr.valid = r_ex3_issue.valid & r_ex3_issue.rd_valid;
  assign o_wr.rnid  = r_ex3_issue.rd_rnid;
  assign o_wr.data  = r_ex3_csr_data;

  assign o_done         = r_ex3_issue.valid;
  assign o_done_index   = r_ex3_index;
  assign o_except_valid = r_ex3_issue.valid &
                          (r_ex3_ctrl.csr_update | r_ex3_ctrl.is_mret | r_ex3_ctrl.is_sret |
                           r_ex3_ctrl.is_uret | r_ex3_ctrl.is_ecall | r_ex3_ctrl.is_fence_i |
                           r_ex3_rd_error | w_ex3_wr_error);

  assign o_except_type = r_ex3_ctrl.is_mret                          ? mret :
                         r_ex3_ctrl.is_sret                          ? sret :
                         r_ex3_ctrl.is_uret                          ? uret :
                         r_ex3_ctrl.is_ecall && (i_priv == prv_u)    ? ecall_u :
                         r_ex3_ctrl.is_ecall && (i_priv == prv_s)    ? ecall_s :
                         r_ex3_ctrl.is_ecall                         ? ecall_m :
                         (r_ex3_rd_error | w_ex3_wr_error)           ? illegal_inst :
                                                                       silent_flush;

  assign o_sfence_valid  = r_ex3_issue.valid & r_ex3_ctrl.is_sfence_vma;
  assign o_sfence_rs1_x0 = w_ex3_rs1_x0;
  assign o_sfence_vaddr  = r_ex3_result;
  assign o_fence_i       = r_ex3_issue.valid & r_ex3_ctrl.is_fence_i;

  // Issue keeps CSR instructions apart
  a_done_spaced: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done |=> !o_done);

  // A CSR write completes the read of the same CSR one cycle earlier
  a_wr_at_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    wr.valid |-> o_done && $past(rd.valid) && (wr.addr == $past(rd.addr)));

endmodule

//--- verilog/csr_file.sv
module csr_file
  import csr_defs_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  priv_t    i_priv,
  input  logic     i_retire,
  csr_rd_if.slave  rd,
  csr_wr_if.slave  wr
);

  logic [xlen_w-1:0] r_mstatus;
  logic [xlen_w-1:0] r_mtvec;
  logic [xlen_w-1:0] r_mepc;
  logic [xlen_w-1:0] r_mcause;
  logic [xlen_w-1:0] r_mscratch;
  logic [xlen_w-1:0] r_minstret;
  logic              w_rd_known;
  logic              w_wr_commit;

  function automatic logic csr_known(input logic [11:0] addr);
    return (addr == csr_mstatus) || (addr == csr_mtvec) || (addr == csr_mepc) ||
           (addr == csr_mcause) || (addr == csr_mscratch) || (addr == csr_minstret);
  endfunction

  // --------------------
  // Read
  // --------------------
  always_comb begin
    w_rd_known = 1'b1;
    case (rd.addr)
      csr_mstatus:  rd.data = r_mstatus;
      csr_mtvec:    rd.data = r_mtvec;
      csr_mepc:     rd.data = r_mepc;
      csr_mcause:   rd.data = r_mcause;
      csr_mscratch: rd.data = r_mscratch;
      csr_minstret: rd.data = r_minstret;
      default: begin
        rd.data    = '0;
        w_rd_known = 1'b0;
      end
    endcase
  end

  assign rd.resp_error = rd.valid & (!w_rd_known | (rd.addr[9:8] > i_priv));

  // --------------------
  // Write
  // --------------------
  assign wr.resp_error = wr.valid & (!csr_known(wr.addr) | (wr.addr[9:8] > i_priv) |
                                     (wr.addr[11:10] == 2'b11));  // Read-only space
  assign w_wr_commit   = wr.valid & !wr.resp_error;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mstatus  <= '0;
      r_mtvec    <= '0;
      r_mepc     <= '0;
      r_mcause   <= '0;
      r_mscratch <= '0;
      r_minstret <= '0;
    end else begin
      if (w_wr_commit) begin
        case (wr.addr)
          csr_mstatus:  r_mstatus  <= wr.data & mstatus_wmask;
          csr_mtvec:    r_mtvec    <= wr.data;
          csr_mepc:     r_mepc     <= wr.data;
          csr_mcause:   r_mcause   <= wr.data;
          csr_mscratch: r_mscratch <= wr.data;
          default: ;
        endcase
      end
      if (w_wr_commit && (wr.addr == csr_minstret)) begin
        r_minstret <= wr.data;  // Write wins over a retire
      end else begin
        r_minstret <= r_minstret + xlen_w'(i_retire);
      end
    end
  end

  a_no_write_on_error: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (wr.valid && wr.resp_error) |=>
      $stable({r_mstatus, r_mtvec, r_mepc, r_mcause, r_mscratch}) &&
      (r_minstret == $past(r_minstret) + xlen_w'($past(i_retire))));

endmodule

//--- verilog/csu_top.sv
module csu_top
  import csr_defs_pkg::*;
  import csu_types_pkg::*;
#(
  parameter int num_tgt = 2,
  parameter int index_w = 8
)(
  input  logic                            i_clk,
  input  logic                            i_reset_n,

  input  logic                            i_issue_valid,
  input  logic [31:0]                     i_issue_inst,
  input  logic                            i_issue_rs1_valid,
  input  logic [rnid_w-1:0]               i_issue_rs1_rnid,
  input  logic                            i_issue_rd_valid,
  input  logic [rnid_w-1:0]               i_issue_rd_rnid,
  input  logic [index_w-1:0]              i_issue_index,

  output logic                            o_rs1_rd_valid,
  output logic [rnid_w-1:0]               o_rs1_rnid,
  input  logic [xlen_w-1:0]               i_rs1_data,

  input  logic [num_tgt-1:0]              i_tgt_valid,
  input  logic [num_tgt-1:0][rnid_w-1:0]  i_tgt_rnid,
  input  logic [num_tgt-1:0][xlen_w-1:0]  i_tgt_data,

  input  priv_t                           i_priv,
  input  logic                            i_retire,

  output logic                            o_early_valid,
  output logic [rnid_w-1:0]               o_early_rnid,
  output logic                            o_wr_valid,
  output logic [rnid_w-1:0]               o_wr_rnid,
  output logic [xlen_w-1:0]               o_wr_data,

  output logic                            o_done,
  output logic [index_w-1:0]              o_done_index,
  output logic                            o_except_valid,
  output except_t                         o_except_type,

  output logic                            o_sfence_valid,
  output logic                            o_sfence_rs1_x0,
  output logic [xlen_w-1:0]               o_sfence_vaddr,
  output logic                            o_fence_i
);

  issue_t  w_issue;
  phy_wr_t w_tgt [num_tgt];
  phy_wr_t w_wr;

  csr_rd_if u_rd_if ();
  csr_wr_if u_wr_if ();

  assign w_issue = '{valid:     i_issue_valid,
                     inst:      i_issue_inst,
                     rs1_valid: i_issue_rs1_valid,
                     rs1_rnid:  i_issue_rs1_rnid,
                     rd_valid:  i_issue_rd_valid,
                     rd_rnid:   i_issue_rd_rnid};

  for (genvar g = 0; g < num_tgt; g++) begin : g_tgt
    assign w_tgt[g] = '{valid: i_tgt_valid[g], rnid: i_tgt_rnid[g], data: i_tgt_data[g]};
  end

  assign o_wr_valid = w_wr.valid;
  assign o_wr_rnid  = w_wr.rnid;
  assign o_wr_data  = w_wr.data;

  csu_pipe #(
    .num_tgt (num_tgt),
    .index_w (index_w)
  ) u_pipe (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_issue         (w_issue),
    .i_index         (i_issue_index),
    .o_rs1_rd_valid  (o_rs1_rd_valid),
    .o_rs1_rnid      (o_rs1_rnid),
    .i_rs1_data      (i_rs1_data),
    .i_tgt           (w_tgt),
    .i_priv          (i_priv),
    .o_early_valid   (o_early_valid),
    .o_early_rnid    (o_early_rnid),
    .o_wr            (w_wr),
    .o_done          (o_done),
    .o_done_index    (o_done_index),
    .o_except_valid  (o_except_valid),
    .o_except_type   (o_except_type),
    .o_sfence_valid  (o_sfence_valid),
    .o_sfence_rs1_x0 (o_sfence_rs1_x0),
    .o_sfence_vaddr  (o_sfence_vaddr),
    .o_fence_i       (o_fence_i),
    .rd              (u_rd_if.master),
    .wr              (u_wr_if.master)
  );

  csr_file u_csr_file (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_priv    (i_priv),
    .i_retire  (i_retire),
    .rd        (u_rd_if.slave),
    .wr        (u_wr_if.slave)
  );

endmodule

//--- tb/tb_csu.sv
module tb_csu
  import csr_defs_pkg::*;
  import csu_types_pkg::*;
();

  localparam int num_tgt    = 2;
  localparam int index_w    = 8;
  localparam int clk_period = 100;
  localparam int num_tests  = 27;  // Issued instructions
  localparam logic [rnid_w-1:0] src_rnid = 6'd12;
  localparam logic [rnid_w-1:0] dst_rnid = 6'd20;

  logic                           i_clk;
  logic                           i_reset_n;
  logic                           i_issue_valid;
  logic [31:0]                    i_issue_inst;
  logic                           i_issue_rs1_valid;
  logic [rnid_w-1:0]              i_issue_rs1_rnid;
  logic                           i_issue_rd_valid;
  logic [rnid_w-1:0]              i_issue_rd_rnid;
  logic [index_w-1:0]             i_issue_index;
  logic [xlen_w-1:0]              i_rs1_data;
  logic [num_tgt-1:0]             i_tgt_valid;
  logic [num_tgt-1:0][rnid_w-1:0] i_tgt_rnid;
  logic [num_tgt-1:0][xlen_w-1:0] i_tgt_data;
  priv_t                          i_priv;
  logic                           i_retire;
  logic                           o_rs1_rd_valid;
  logic [rnid_w-1:0]              o_rs1_rnid;
  logic                           o_early_valid;
  logic [rnid_w-1:0]              o_early_rnid;
  logic                           o_wr_valid;
  logic [rnid_w-1:0]              o_wr_rnid;
  logic [xlen_w-1:0]              o_wr_data;
  logic                           o_done;
  logic [index_w-1:0]             o_done_index;
  logic                           o_except_valid;
  except_t                        o_except_type;
  logic                           o_sfence_valid;
  logic                           o_sfence_rs1_x0;
  logic [xlen_w-1:0]              o_sfence_vaddr;
  logic                           o_fence_i;

  logic [xlen_w-1:0] csr_ref [4096];        // Expected CSR contents
  logic [xlen_w-1:0] prf [1 << rnid_w];     // Physical register file model
  phy_wr_t           fwd_set [num_tgt];     // Bus entries shown at ex2
  integer            seed = 44230;
  int                errors = 0;
  int                checks = 0;
  int                inst_cnt = 0;
  phy_wr_t           got_wr;
  logic              got_except_valid;
  except_t           got_except;
  logic              got_sfence_valid;
  logic              got_sfence_rs1_x0;
  logic [xlen_w-1:0] got_vaddr;
  logic              got_fence_i;

  csu_top #(.num_tgt(num_tgt), .index_w(index_w)) DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #(clk_period / 2) i_clk = ~i_clk;
  end

  // Each instruction takes about six cycles, so twenty is a wide margin
  initial begin
    #(num_tests * 20 * clk_period);
    $display("watchdog expired, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  // --------------------
  // Checks
  // --------------------
  task automatic check_data(input logic [xlen_w-1:0] got, input logic [xlen_w-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_except(input except_t got, input except_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_wr(input phy_wr_t got, input phy_wr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Drivers
  // --------------------
  function automatic logic [31:0] encode_csr(input logic [11:0] csr, input logic [4:0] rs1,
                                             input logic [2:0] funct3);
    return {csr, rs1, funct3, 5'd1, 7'b1110011};
  endfunction

  task automatic set_priv(input priv_t p);
    @(posedge i_clk);
    i_priv <= p;
  endtask

  task automatic run_inst(input logic [31:0] inst, input logic rs1_valid,
                          input logic [rnid_w-1:0] rs1_rnid, input logic rd_valid);
    logic [index_w-1:0] index;
    logic               seen;
    index = index_w'(1) << (inst_cnt % index_w);
    inst_cnt++;
    @(posedge i_clk);
    i_issue_valid     <= 1'b1;
    i_issue_inst      <= inst;
    i_issue_rs1_valid <= rs1_valid;
    i_issue_rs1_rnid  <= rs1_rnid;
    i_issue_rd_valid  <= rd_valid;
    i_issue_rd_rnid   <= dst_rnid;
    i_issue_index     <= index;
    @(posedge i_clk);  // ex1 requests rs1
    i_issue_valid <= 1'b0;
    @(negedge i_clk);
    check_flag(o_rs1_rd_valid, rs1_valid, "rs1 read request");
    if (rs1_valid) check_data(xlen_w'(o_rs1_rnid), xlen_w'(rs1_rnid), "rs1 read rnid");
    check_flag(o_early_valid, rd_valid, "early write");
    if (rd_valid) check_data(xlen_w'(o_early_rnid), xlen_w'(dst_rnid), "early write rnid");
    @(posedge i_clk);  // Register file answers, buses shown for ex2
    i_rs1_data <= prf[rs1_rnid];
    for (int g = 0; g < num_tgt; g++) begin
      i_tgt_valid[g] <= fwd_set[g].valid;
      i_tgt_rnid[g]  <= fwd_set[g].rnid;
      i_tgt_data[g]  <= fwd_set[g].data;
    end
    @(posedge i_clk);
    i_tgt_valid <= '0;
    seen = 1'b0;
    for (int n = 0; n < 4 && !seen; n++) begin
      @(negedge i_clk);
      seen = o_done;
    end
    if (!seen) begin
      errors++;
      $display("no done within four cycles of the issue, time %0t", $time);
    end else begin
      got_wr.valid      = o_wr_valid;
      got_wr.rnid       = o_wr_rnid;
      got_wr.data       = o_wr_data;
      got_except_valid  = o_except_valid;
      got_except        = o_except_type;
      got_sfence_valid  = o_sfence_valid;
      got_sfence_rs1_x0 = o_sfence_rs1_x0;
      got_vaddr         = o_sfence_vaddr;
      got_fence_i       = o_fence_i;
      check_data(xlen_w'(o_done_index), xlen_w'(index), "done index");
    end
  endtask

  // Mode 1 forwards the operand on bus 1, mode 2 offers a bus entry with rnid 0
  task automatic exec_csr(input logic [2:0] funct3, input logic [11:0] csr,
                          input logic [4:0] rs1, input logic [xlen_w-1:0] operand,
                          input int fwd_mode, input logic illegal);
    logic [xlen_w-1:0] src;
    logic [xlen_w-1:0] old_val;
    logic [xlen_w-1:0] new_val;
    logic [rnid_w-1:0] rnid;
    phy_wr_t           exp_wr;
    src       = funct3[2] ? xlen_w'(rs1) : operand;
    old_val   = csr_ref[csr];
    rnid      = (fwd_mode == 2) ? '0 : src_rnid;
    prf[rnid] = (fwd_mode == 1) ? ~operand : operand;
    if (fwd_mode == 1) begin
      fwd_set[0] = '{1'b1, src_rnid + 6'd1, $random(seed)};
      fwd_set[1] = '{1'b1, src_rnid, operand};
    end else if (fwd_mode == 2) begin
      fwd_set[0] = '{1'b1, 6'd0, ~operand};
    end
    case (funct3[1:0])
      2'b01:   new_val = src;
      2'b10:   new_val = old_val | src;
      default: new_val = old_val & ~src;
    endcase
    if (funct3[1:0] != 2'b01 && rs1 == 5'd0) new_val = old_val;  // Pure read
    run_inst(encode_csr(csr, rs1, funct3), !funct3[2], rnid, 1'b1);
    fwd_set[0] = '0;
    fwd_set[1] = '0;
    if (illegal) begin
      check_flag(got_except_valid, 1'b1, "illegal access flagged");
      check_except(got_except, illegal_inst, "illegal access cause");
    end else begin
      exp_wr = '{1'b1, dst_rnid, old_val};
      check_wr(got_wr, exp_wr, "old csr value to rd");
      check_flag(got_except_valid, 1'b1, "csr access flagged");
      check_except(got_except, silent_flush, "csr access cause");
      csr_ref[csr] = new_val;
    end
  endtask

  task automatic run_sys(input logic [31:0] inst, input logic exp_valid,
                         input except_t exp_type, input string what);
    run_inst(inst, 1'b0, '0, 1'b0);
    check_flag(got_except_valid, exp_valid, what);
    if (exp_valid) check_except(got_except, exp_type, what);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_csrrw();
    exec_csr(3'b001, csr_mscratch, 5'd5, $random(seed), 0, 1'b0);
    exec_csr(3'b010, csr_mscratch, 5'd0, '0, 0, 1'b0);  // csrr sees the new value
  endtask

  task automatic test_set_clear();
    exec_csr(3'b010, csr_mscratch, 5'd6, $random(seed), 0, 1'b0);
    exec_csr(3'b011, csr_mscratch, 5'd7, $random(seed), 0, 1'b0);
    exec_csr(3'b110, csr_mtvec, 5'd21, '0, 0, 1'b0);
    exec_csr(3'b111, csr_mtvec, 5'd5, '0, 0, 1'b0);
    exec_csr(3'b010, csr_mscratch, 5'd0, $random(seed), 0, 1'b0);
    exec_csr(3'b010, csr_mscratch, 5'd0, '0, 0, 1'b0);
  endtask

  task automatic test_forwarding();
    exec_csr(3'b001, csr_mepc, 5'd9, $random(seed), 1, 1'b0);
    exec_csr(3'b010, csr_mepc, 5'd9, $random(seed), 2, 1'b0);
    exec_csr(3'b010, csr_mepc, 5'd0, '0, 0, 1'b0);
  endtask

  task automatic test_privilege();
    set_priv(prv_u);
    exec_csr(3'b001, csr_mscratch, 5'd5, $random(seed), 0, 1'b1);
    set_priv(prv_m);
    exec_csr(3'b010, csr_mscratch, 5'd0, '0, 0, 1'b0);
    exec_csr(3'b001, 12'hf11, 5'd5, $random(seed), 0, 1'b1);  // Read-only space
  endtask

  task automatic test_system();
    priv_t             p;
    except_t           ecall_exp;
    logic [xlen_w-1:0] vaddr;
    for (int i = 0; i < 3; i++) begin
      case (i)
        0:       begin p = prv_u; ecall_exp = ecall_u; end
        1:       begin p = prv_s; ecall_exp = ecall_s; end
        default: begin p = prv_m; ecall_exp = ecall_m; end
      endcase
      set_priv(p);
      run_sys(32'h3020_0073, 1'b1, mret, "mret");
      run_sys(32'h1020_0073, 1'b1, sret, "sret");
      run_sys(32'h0000_0073, 1'b1, ecall_exp, "ecall");
    end
    set_priv(prv_m);
    run_sys(32'h0000_100f, 1'b1, silent_flush, "fence.i");
    check_flag(got_fence_i, 1'b1, "fence.i strobe");
    vaddr = $random(seed);
    prf[src_rnid] = vaddr;
    run_inst({7'b0001001, 5'd0, 5'd11, 3'b000, 5'd0, 7'b1110011}, 1'b1, src_rnid, 1'b0);
    check_flag(got_sfence_valid, 1'b1, "sfence.vma strobe");
    check_flag(got_sfence_rs1_x0, 1'b0, "sfence.vma rs1 not x0");
    check_data(got_vaddr, vaddr, "sfence.vma address");
    check_flag(got_except_valid, 1'b0, "sfence.vma no exception");
    // Whole address space flush
    run_inst({7'b0001001, 5'd0, 5'd0, 3'b000, 5'd0, 7'b1110011}, 1'b0, '0, 1'b0);
    check_flag(got_sfence_valid, 1'b1, "sfence.vma x0 strobe");
    check_flag(got_sfence_rs1_x0, 1'b1, "sfence.vma rs1 x0");
  endtask

  task automatic test_minstret();
    int   count;
    logic pulse;
    count = 0;
    for (int i = 0; i < 24; i++) begin
      pulse = 1'($random(seed));
      @(posedge i_clk);
      i_retire <= pulse;
      count = count + int'(pulse);
    end
    @(posedge i_clk);
    i_retire <= 1'b0;
    csr_ref[csr_minstret] = csr_ref[csr_minstret] + xlen_w'(count);
    exec_csr(3'b010, csr_minstret, 5'd0, '0, 0, 1'b0);
  endtask

  initial begin
    i_reset_n         = 1'b0;
    i_issue_valid     = 1'b0;
    i_issue_inst      = '0;
    i_issue_rs1_valid = 1'b0;
    i_issue_rs1_rnid  = '0;
    i_issue_rd_valid  = 1'b0;
    i_issue_rd_rnid   = '0;
    i_issue_index     = '0;
    i_rs1_data        = '0;
    i_tgt_valid       = '0;
    i_tgt_rnid        = '0;
    i_tgt_data        = '0;
    i_priv            = prv_m;
    i_retire          = 1'b0;
    for (int a = 0; a < 4096; a++) csr_ref[a] = '0;
    for (int r = 0; r < (1 << rnid_w); r++) prf[r] = '0;
    for (int g = 0; g < num_tgt; g++) fwd_set[g] = '0;
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    test_csrrw();
    test_set_clear();
    test_forwarding();
    test_privilege();
    test_system();
    test_minstret();
    repeat (2) @(posedge i_clk);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- files.f
verilog/csr_defs_pkg.sv
verilog/csu_types_pkg.sv
verilog/csu_ifs.sv
verilog/csu_decoder.sv
verilog/csu_pipe.sv
verilog/csr_file.sv
verilog/csu_top.sv
tb/tb_csu.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module csu_top -f files.f

sim:
	verilator --binary --timing --assert --top-module tb_csu -f files.f -o tb_csu
	@out="$$(./obj_dir/tb_csu)"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
